// File: hw/ucode_params.svh
// ----------------------------------------
// Microcode control unit widths
// ----------------------------------------

`ifndef UCODE_PARAMS_SVH
`define UCODE_PARAMS_SVH

// Instruction word as fetched from RAM
`define UC_INSTR_WIDTH 16

// Step counter, enough for the longest instruction of five steps
`define UC_STEP_WIDTH 3

// Control word driving the bus strobes
`define UC_CW_WIDTH 24

// ALU operation field in the low bits of the control word
`define UC_ALU_OP_WIDTH 4

`endif

// File: hw/ucode_pkg.sv
// ----------------------------------------
// Control word masks, ALU codes and opcodes
// ----------------------------------------

`include "ucode_params.svh"

package ucode_pkg;

  // Bits 3:0 hold the ALU operation, the strobes sit above them
  localparam logic [`UC_CW_WIDTH-1:0] c_lsb = {{(`UC_CW_WIDTH-1){1'b0}}, 1'b1};
  localparam logic [`UC_CW_WIDTH-1:0] c_mi  = c_lsb << 4;
  localparam logic [`UC_CW_WIDTH-1:0] c_ri  = c_lsb << 5;
  localparam logic [`UC_CW_WIDTH-1:0] c_ro  = c_lsb << 6;
  localparam logic [`UC_CW_WIDTH-1:0] c_ii  = c_lsb << 7;
  localparam logic [`UC_CW_WIDTH-1:0] c_co  = c_lsb << 8;
  localparam logic [`UC_CW_WIDTH-1:0] c_ce  = c_lsb << 9;
  localparam logic [`UC_CW_WIDTH-1:0] c_j   = c_lsb << 10;
  localparam logic [`UC_CW_WIDTH-1:0] c_ari = c_lsb << 11;
  localparam logic [`UC_CW_WIDTH-1:0] c_aro = c_lsb << 12;
  localparam logic [`UC_CW_WIDTH-1:0] c_bri = c_lsb << 13;
  localparam logic [`UC_CW_WIDTH-1:0] c_bro = c_lsb << 14;
  localparam logic [`UC_CW_WIDTH-1:0] c_cri = c_lsb << 15;
  localparam logic [`UC_CW_WIDTH-1:0] c_cro = c_lsb << 16;
  localparam logic [`UC_CW_WIDTH-1:0] c_tri = c_lsb << 17;
  localparam logic [`UC_CW_WIDTH-1:0] c_tro = c_lsb << 18;
  localparam logic [`UC_CW_WIDTH-1:0] c_oi  = c_lsb << 19;
  localparam logic [`UC_CW_WIDTH-1:0] c_eo  = c_lsb << 20;
  localparam logic [`UC_CW_WIDTH-1:0] c_el  = c_lsb << 21;
  localparam logic [`UC_CW_WIDTH-1:0] c_adv = c_lsb << 22;
  localparam logic [`UC_CW_WIDTH-1:0] c_hlt = c_lsb << 23;

  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_add  = 4'h0;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_sub  = 4'h1;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_and  = 4'h2;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_or   = 4'h3;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_xor  = 4'h4;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_sl   = 4'h5;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_sr   = 4'h6;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_asr  = 4'h7;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_rol  = 4'h8;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_ror  = 4'h9;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_rolc = 4'ha;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_rorc = 4'hb;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_inv  = 4'hc;
  localparam logic [`UC_ALU_OP_WIDTH-1:0] alu_chk  = 4'hd;

  // Direct loads and stores, the address is the next word in RAM
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ld_a    = 16'h0001;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ld_b    = 16'h0002;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ld_c    = 16'h0003;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_st_a    = 16'h0004;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_st_t    = 16'h0005;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_st_b    = 16'h0006;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_st_c    = 16'h0007;
  // Indirect through T
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ldt_a   = 16'h0008;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ldt_b   = 16'h0009;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ldt_c   = 16'h000a;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_stt_a   = 16'h000b;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_stt_b   = 16'h000c;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_stt_c   = 16'h000d;
  // Register moves, named source then destination
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_a_t = 16'h000e;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_a_b = 16'h000f;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_a_c = 16'h0010;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_t_a = 16'h0011;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_t_b = 16'h0012;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_t_c = 16'h0013;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_b_a = 16'h0014;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_b_t = 16'h0015;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_b_c = 16'h0016;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_c_a = 16'h0017;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_c_t = 16'h0018;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_mov_c_b = 16'h0019;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_out_a   = 16'h0026;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_out_t   = 16'h0027;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_out_b   = 16'h0028;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_out_c   = 16'h0029;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ldi_a   = 16'h002a;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ldi_b   = 16'h002b;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ldi_c   = 16'h002c;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_jmp     = 16'h002d;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_jiz     = 16'h002e;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_jic     = 16'h002f;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_jio     = 16'h0030;
  // ALU with an immediate operand from the next word in RAM
  localparam logic [`UC_INSTR_WIDTH-1:0] op_addi    = 16'h0031;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_subi    = 16'h0032;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_andi    = 16'h0033;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ori     = 16'h0034;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_xori    = 16'h0035;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_add_b   = 16'h0036;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_sub_b   = 16'h0037;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_and_b   = 16'h0038;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_or_b    = 16'h0039;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_xor_b   = 16'h003a;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_add_c   = 16'h003b;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_sub_c   = 16'h003c;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_and_c   = 16'h003d;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_or_c    = 16'h003e;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_xor_c   = 16'h003f;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_sl      = 16'h0040;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_sr      = 16'h0041;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_asr     = 16'h0042;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_rol     = 16'h0043;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_ror     = 16'h0044;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_rolc    = 16'h0045;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_rorc    = 16'h0046;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_inv     = 16'h0047;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_chk     = 16'h0048;
  localparam logic [`UC_INSTR_WIDTH-1:0] op_halt    = 16'hffff;

endpackage

// File: hw/ucode_if.sv
// ----------------------------------------
// Decode request from sequencer to decoders
// ----------------------------------------

`timescale 1ns/1ps

`include "ucode_params.svh"

interface ucode_if;

  logic [`UC_INSTR_WIDTH-1:0] instr;
  logic [`UC_STEP_WIDTH-1:0]  step;
  logic                       zero;
  logic                       carry;
  logic                       odd;

  modport seq (output instr, output step, output zero, output carry, output odd);

  modport dec (input instr, input step, input zero, input carry, input odd);

endinterface

// File: hw/transfer_decoder.sv
// ----------------------------------------
// Decoder for loads, stores, moves, OUT
// and jumps
// ----------------------------------------

`timescale 1ns/1ps

`include "ucode_params.svh"

module transfer_decoder
  import ucode_pkg::*;
(
  ucode_if.dec                    dec,
  output logic                    o_hit,
  output logic [`UC_CW_WIDTH-1:0] o_word
);

  logic [`UC_CW_WIDTH-1:0] route;
  logic [`UC_CW_WIDTH-1:0] word_s2;
  logic [`UC_CW_WIDTH-1:0] word_s3;
  logic                    is_load;
  logic                    is_store;
  logic                    is_ldt;
  logic                    is_stt;
  logic                    is_mov;
  logic                    is_out;
  logic                    is_jump;
  logic                    take;

  // Register strobes for each opcode, destination in for loads and source out for stores
  always_comb begin
    case (dec.instr)
      op_ld_a, op_ldi_a, op_ldt_a: route = c_ari;
      op_ld_b, op_ldi_b, op_ldt_b: route = c_bri;
      op_ld_c, op_ldi_c, op_ldt_c: route = c_cri;
      op_st_a, op_stt_a, op_out_a: route = c_aro;
      op_st_t, op_out_t:           route = c_tro;
      op_st_b, op_stt_b, op_out_b: route = c_bro;
      op_st_c, op_stt_c, op_out_c: route = c_cro;
      op_mov_a_t:                  route = c_aro | c_tri;
      op_mov_a_b:                  route = c_aro | c_bri;
      op_mov_a_c:                  route = c_aro | c_cri;
      op_mov_t_a:                  route = c_tro | c_ari;
      op_mov_t_b:                  route = c_tro | c_bri;
      op_mov_t_c:                  route = c_tro | c_cri;
      op_mov_b_a:                  route = c_bro | c_ari;
      op_mov_b_t:                  route = c_bro | c_tri;
      op_mov_b_c:                  route = c_bro | c_cri;
      op_mov_c_a:                  route = c_cro | c_ari;
      op_mov_c_t:                  route = c_cro | c_tri;
      op_mov_c_b:                  route = c_cro | c_bri;
      default:                     route = '0;
    endcase
  end

  // JMP is always taken, the others follow their flag
  always_comb begin
    case (dec.instr)
      op_jiz:  take = dec.zero;
      op_jic:  take = dec.carry;
      op_jio:  take = dec.odd;
      default: take = 1'b1;
    endcase
  end

  assign is_load  = dec.instr inside {[op_ld_a:op_ld_c], [op_ldi_a:op_ldi_c]};
  assign is_store = dec.instr inside {[op_st_a:op_st_c]};
  assign is_ldt   = dec.instr inside {[op_ldt_a:op_ldt_c]};
  assign is_stt   = dec.instr inside {[op_stt_a:op_stt_c]};
  assign is_mov   = dec.instr inside {[op_mov_a_t:op_mov_c_b]};
  assign is_out   = dec.instr inside {[op_out_a:op_out_c]};
  assign is_jump  = dec.instr inside {[op_jmp:op_jio]};

  assign o_hit = is_load | is_store | is_ldt | is_stt | is_mov | is_out | is_jump;

  always_comb begin
    word_s2 = '0;
    word_s3 = '0;
    if (is_load || is_store) begin
      word_s2 = c_mi | c_co | c_ce;
      word_s3 = (is_load ? c_ro : c_ri) | route | c_adv;
    end else if (is_ldt || is_stt) begin
      word_s2 = c_mi | c_tro;
      word_s3 = (is_ldt ? c_ro : c_ri) | route | c_adv;
    end else if (is_mov) begin
      word_s2 = route | c_adv;
    end else if (is_out) begin
      word_s2 = route | c_oi | c_adv;
    end else if (is_jump) begin
      // A jump not taken still steps the PC over the target word
      word_s2 = c_mi | c_co | c_ce | (take ? '0 : c_adv);
      word_s3 = c_ro | c_j | c_adv;
    end
  end

  always_comb begin
    case (dec.step)
      'd2:     o_word = word_s2;
      'd3:     o_word = word_s3;
      default: o_word = '0;
    endcase
  end

endmodule

// File: hw/alu_op_decoder.sv
// ----------------------------------------
// Decoder for ALU, shift and rotate ops
// ----------------------------------------

`timescale 1ns/1ps

`include "ucode_params.svh"

module alu_op_decoder
  import ucode_pkg::*;
(
  ucode_if.dec                    dec,
  output logic                    o_hit,
  output logic [`UC_CW_WIDTH-1:0] o_word
);

  logic [`UC_ALU_OP_WIDTH-1:0] alu_op;
  logic [`UC_CW_WIDTH-1:0]     compute;
  logic [`UC_CW_WIDTH-1:0]     word_s2;
  logic [`UC_CW_WIDTH-1:0]     word_s3;
  logic [`UC_CW_WIDTH-1:0]     word_s4;
  logic                        is_imm;
  logic                        is_reg_b;
  logic                        is_reg_c;
  logic                        is_single;

  always_comb begin
    case (dec.instr)
      op_subi, op_sub_b, op_sub_c: alu_op = alu_sub;
      op_andi, op_and_b, op_and_c: alu_op = alu_and;
      op_ori, op_or_b, op_or_c:    alu_op = alu_or;
      op_xori, op_xor_b, op_xor_c: alu_op = alu_xor;
      op_sl:                       alu_op = alu_sl;
      op_sr:                       alu_op = alu_sr;
      op_asr:                      alu_op = alu_asr;
      op_rol:                      alu_op = alu_rol;
      op_ror:                      alu_op = alu_ror;
      op_rolc:                     alu_op = alu_rolc;
      op_rorc:                     alu_op = alu_rorc;
      op_inv:                      alu_op = alu_inv;
      op_chk:                      alu_op = alu_chk;
      default:                     alu_op = alu_add;
    endcase
  end

  assign is_imm    = dec.instr inside {[op_addi:op_xori]};
  assign is_reg_b  = dec.instr inside {[op_add_b:op_xor_b]};
  assign is_reg_c  = dec.instr inside {[op_add_c:op_xor_c]};
  assign is_single = dec.instr inside {[op_sl:op_chk]};

  assign o_hit = is_imm | is_reg_b | is_reg_c | is_single;

  // The result always lands in T and the flags latch with it
  assign compute = c_eo | c_tri | c_el | c_adv |
                   {{(`UC_CW_WIDTH-`UC_ALU_OP_WIDTH){1'b0}}, alu_op};

  always_comb begin
    word_s2 = '0;
    word_s3 = '0;
    word_s4 = '0;
    if (is_imm) begin
      word_s2 = c_mi | c_co | c_ce;
      word_s3 = c_ro | c_tri;
      word_s4 = compute;
    end else if (is_reg_b || is_reg_c) begin
      word_s2 = (is_reg_b ? c_bro : c_cro) | c_tri;
      word_s3 = compute;
    end else if (is_single) begin
      word_s2 = compute;
    end
  end

  always_comb begin
    case (dec.step)
      'd2:     o_word = word_s2;
      'd3:     o_word = word_s3;
      'd4:     o_word = word_s4;
      default: o_word = '0;
    endcase
  end

endmodule

// File: hw/microcode_sequencer.sv
// ----------------------------------------
// Step counter, fetch words and merging
// of the decoder results
// ----------------------------------------

`timescale 1ns/1ps

`include "ucode_params.svh"

module microcode_sequencer
  import ucode_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic [`UC_INSTR_WIDTH-1:0]  i_instruction,
  input  logic                        i_zero,
  input  logic                        i_carry,
  input  logic                        i_odd,
  input  logic                        i_xfer_hit,
  input  logic [`UC_CW_WIDTH-1:0]     i_xfer_word,
  input  logic                        i_alu_hit,
  input  logic [`UC_CW_WIDTH-1:0]     i_alu_word,
  ucode_if.seq                        bus,
  output logic [`UC_CW_WIDTH-1:0]     o_control_word,
  output logic [`UC_STEP_WIDTH-1:0]   o_step
);

  logic [`UC_STEP_WIDTH-1:0] step_q;
  logic                      word_adv;
  logic                      word_hlt;

  assign bus.instr = i_instruction;
  assign bus.step  = step_q;
  assign bus.zero  = i_zero;
  assign bus.carry = i_carry;
  assign bus.odd   = i_odd;

  always_comb begin
    case (step_q)
      // PC to the address register, then read the instruction and bump the PC
      'd0:     o_control_word = c_mi | c_co;
      'd1:     o_control_word = c_ro | c_ii | c_ce;
      default: begin
        if (i_xfer_hit) begin
          o_control_word = i_xfer_word;
        end else if (i_alu_hit) begin
          o_control_word = i_alu_word;
        end else if (step_q != 'd2) begin
          o_control_word = '0;
        end else if (i_instruction == op_halt) begin
          o_control_word = c_hlt;
        end else begin
          // Unknown opcodes behave as NOP
          o_control_word = c_adv;
        end
      end
    endcase
  end

  assign word_adv = |(o_control_word & c_adv);
  assign word_hlt = |(o_control_word & c_hlt);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      step_q <= '0;
    end else if (word_adv) begin
      step_q <= '0;
    end else if (!word_hlt) begin
      step_q <= step_q + 1'b1;
    end
  end

  assign o_step = step_q;

endmodule

// File: hw/instruction_decoder.sv
// ----------------------------------------
// Microcode control unit top level
// ----------------------------------------

`timescale 1ns/1ps

`include "ucode_params.svh"

module instruction_decoder (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic [`UC_INSTR_WIDTH-1:0]  i_instruction,
  input  logic                        i_zero,
  input  logic                        i_carry,
  input  logic                        i_odd,
  output logic [`UC_CW_WIDTH-1:0]     o_control_word,
  output logic [`UC_STEP_WIDTH-1:0]   o_step
);

  logic                    xfer_hit;
  logic [`UC_CW_WIDTH-1:0] xfer_word;
  logic                    alu_hit;
  logic [`UC_CW_WIDTH-1:0] alu_word;

  // Shared request seen by both decoders
  ucode_if u_dec_bus ();

  microcode_sequencer u_sequencer (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_instruction  (i_instruction),
    .i_zero         (i_zero),
    .i_carry        (i_carry),
    .i_odd          (i_odd),
    .i_xfer_hit     (xfer_hit),
    .i_xfer_word    (xfer_word),
    .i_alu_hit      (alu_hit),
    .i_alu_word     (alu_word),
    .bus            (u_dec_bus),
    .o_control_word (o_control_word),
    .o_step         (o_step)
  );

  transfer_decoder u_transfer_decoder (
    .dec    (u_dec_bus),
    .o_hit  (xfer_hit),
    .o_word (xfer_word)
  );

  alu_op_decoder u_alu_op_decoder (
    .dec    (u_dec_bus),
    .o_hit  (alu_hit),
    .o_word (alu_word)
  );

endmodule

// File: tb/tb_clk_gen.sv
// ----------------------------------------
// Free running testbench clock
// ----------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns = 10
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #(period_ns / 2) o_clk = ~o_clk;

endmodule

// File: tb/instruction_decoder_chk.sv
// ----------------------------------------
// Control word and step assertions for
// the microcode control unit
// ----------------------------------------

`timescale 1ns/1ps

`include "ucode_params.svh"

module instruction_decoder_chk
  import ucode_pkg::*;
(
  input logic                       i_clk,
  input logic                       i_rst_n,
  input logic [`UC_INSTR_WIDTH-1:0] i_instruction,
  input logic                       i_zero,
  input logic                       i_carry,
  input logic                       i_odd,
  input logic [`UC_CW_WIDTH-1:0]    i_control_word,
  input logic [`UC_STEP_WIDTH-1:0]  i_step
);

  // Register strobes in the order A, T, B, C
  localparam logic [4*`UC_CW_WIDTH-1:0] in_set  = {c_cri, c_bri, c_tri, c_ari};
  localparam logic [4*`UC_CW_WIDTH-1:0] out_set = {c_cro, c_bro, c_tro, c_aro};
  localparam logic [5*`UC_ALU_OP_WIDTH-1:0] arith_set =
    {alu_xor, alu_or, alu_and, alu_sub, alu_add};
  localparam logic [9*`UC_ALU_OP_WIDTH-1:0] single_set =
    {alu_chk, alu_inv, alu_rorc, alu_rolc, alu_ror, alu_rol, alu_asr, alu_sr, alu_sl};

  logic                    adv;
  logic                    hlt;
  logic                    taken;
  logic                    exp_adv;
  logic [`UC_CW_WIDTH-1:0] exp_word;
  int unsigned             fail_count = 0;

  function automatic logic [`UC_CW_WIDTH-1:0] reg_in(input int r);
    return in_set[r*`UC_CW_WIDTH +: `UC_CW_WIDTH];
  endfunction

  function automatic logic [`UC_CW_WIDTH-1:0] reg_out(input int r);
    return out_set[r*`UC_CW_WIDTH +: `UC_CW_WIDTH];
  endfunction

  // Groups without T count A, B, C
  function automatic int abc(input int i);
    return (i == 0) ? 0 : i + 1;
  endfunction

  // Step that must carry ADV, 7 is never reached
  function automatic int adv_step(input int op, input logic tk);
    if (op == op_halt) return 7;
    if (op >= op_ld_a && op <= op_stt_c) return 3;
    if (op >= op_ldi_a && op <= op_jio) return (op >= op_jiz && !tk) ? 2 : 3;
    if (op >= op_addi && op <= op_xori) return 4;
    if (op >= op_add_b && op <= op_xor_c) return 3;
    return 2;
  endfunction

  // Word expected at the ADV step, or the HLT word
  function automatic logic [`UC_CW_WIDTH-1:0] adv_word(input int op, input logic tk);
    int                      k;
    int                      s;
    int                      d;
    logic [`UC_CW_WIDTH-1:0] alu;
    logic [`UC_CW_WIDTH-1:0] w;
    k = op - int'(op_mov_a_t);
    s = k / 3;
    d = k % 3;
    alu = c_eo | c_tri | c_el;
    w = '0;
    if (op >= op_ld_a && op <= op_ld_c) w = c_ro | reg_in(abc(op - op_ld_a));
    if (op >= op_st_a && op <= op_st_c) w = c_ri | reg_out(op - op_st_a);
    if (op >= op_ldt_a && op <= op_ldt_c) w = c_ro | reg_in(abc(op - op_ldt_a));
    if (op >= op_stt_a && op <= op_stt_c) w = c_ri | reg_out(abc(op - op_stt_a));
    if (op >= op_mov_a_t && op <= op_mov_c_b) w = reg_out(s) | reg_in(d >= s ? d + 1 : d);
    if (op >= op_out_a && op <= op_out_c) w = c_oi | reg_out(op - op_out_a);
    if (op >= op_ldi_a && op <= op_ldi_c) w = c_ro | reg_in(abc(op - op_ldi_a));
    if (op >= op_jmp && op <= op_jio) w = tk ? (c_ro | c_j) : (c_mi | c_co | c_ce);
    if (op >= op_addi && op <= op_xor_c) w = alu | arith_set[((op - op_addi) % 5) * 4 +: 4];
    if (op >= op_sl && op <= op_chk) w = alu | single_set[(op - op_sl) * 4 +: 4];
    return (op == op_halt) ? c_hlt : (w | c_adv);
  endfunction

  assign adv = |(i_control_word & c_adv);
  assign hlt = |(i_control_word & c_hlt);

  always_comb begin
    case (i_instruction)
      op_jiz:  taken = i_zero;
      op_jic:  taken = i_carry;
      op_jio:  taken = i_odd;
      default: taken = 1'b1;
    endcase
  end

  assign exp_adv = (int'(i_step) == adv_step(int'(i_instruction), taken));

  always_comb begin
    case (i_step)
      'd0:     exp_word = c_mi | c_co;
      'd1:     exp_word = c_ro | c_ii | c_ce;
      default: exp_word = adv_word(int'(i_instruction), taken);
    endcase
  end

  a_word: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_step < 2 || adv || i_instruction == op_halt) |-> i_control_word == exp_word)
    else begin
      fail_count++;
      $error("mismatch at %0t: o_control_word expected %h got %h",
             $time, $sampled(exp_word), $sampled(i_control_word));
    end

  a_adv_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_step >= 2 |-> adv == exp_adv)
    else begin
      fail_count++;
      $error("mismatch at %0t: o_control_word ADV at step %0d expected %b got %b",
             $time, $sampled(i_step), $sampled(exp_adv), $sampled(adv));
    end

  a_adv_return: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      adv |=> i_step == 0)
    else begin
      fail_count++;
      $error("step counter did not return to 0 one edge after ADV at %0t", $time);
    end

  a_halt_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      hlt |=> i_step == $past(i_step))
    else begin
      fail_count++;
      $error("step counter moved while HLT was set at %0t", $time);
    end

  a_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> i_step == 0 && !hlt)
    else begin
      fail_count++;
      $error("step not 0 or HLT set right after reset at %0t", $time);
    end

endmodule

bind instruction_decoder instruction_decoder_chk u_chk (
  .i_clk          (i_clk),
  .i_rst_n        (i_rst_n),
  .i_instruction  (i_instruction),
  .i_zero         (i_zero),
  .i_carry        (i_carry),
  .i_odd          (i_odd),
  .i_control_word (o_control_word),
  .i_step         (o_step)
);

// File: tb/instruction_decoder_tb.sv
// ----------------------------------------
// Testbench for the microcode control unit
// ----------------------------------------

`timescale 1ns/1ps

`include "ucode_params.svh"

module instruction_decoder_tb
  import ucode_pkg::*;
();

  localparam int period_ns    = 10;
  localparam int reset_cycles = 5;
  localparam int n_random     = 16;
  localparam int halt_cycles  = 16;
  // Reset NOP, transfers, six jumps, ALU ops, random NOPs and HALT
  localparam int n_instr = 1 + int'(op_jmp) + 6 + int'(op_chk - op_jio) + n_random + 1;
  localparam int watchdog_ns = (2 * reset_cycles + 20 * n_instr) * period_ns;

  logic                        clk;
  logic                        rst_n;
  logic [`UC_INSTR_WIDTH-1:0]  instruction;
  logic                        zero;
  logic                        carry;
  logic                        odd;
  logic [`UC_CW_WIDTH-1:0]     control_word;
  logic [`UC_STEP_WIDTH-1:0]   step;
  logic [31:0]                 lfsr_state;
  int                          tests_run;
  int                          tests_failed;
  int unsigned                 errors_at_start;

  tb_clk_gen #(.period_ns(period_ns)) u_clk_gen (.o_clk(clk));

  instruction_decoder i_instruction_decoder (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_instruction  (instruction),
    .i_zero         (zero),
    .i_carry        (carry),
    .i_odd          (odd),
    .o_control_word (control_word),
    .o_step         (step)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
  endtask

  function automatic logic is_unknown(input logic [15:0] op);
    return op != op_halt && (op == 0 || op > op_chk || (op > op_mov_c_b && op < op_out_a));
  endfunction

  task automatic reset_dut();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // Apply an opcode while the step is 0, then wait for the step to come back to 0
  task automatic run_instr(input logic [15:0] op, input logic [2:0] flags);
    @(posedge clk);
    instruction <= op;
    {zero, carry, odd} <= flags;
    @(negedge clk);
    while (step != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic start_test();
    errors_at_start = i_instruction_decoder.u_chk.fail_count;
  endtask

  task automatic finish_test(input string name);
    int unsigned errs;
    errs = i_instruction_decoder.u_chk.fail_count - errors_at_start;
    tests_run++;
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d assertion failures", name, errs);
    end
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns with the tests still running", watchdog_ns);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [15:0] op;
    logic [15:0] flags;
    rst_n = 1'b0;
    instruction = '0;
    zero = 1'b0;
    carry = 1'b0;
    odd = 1'b0;
    lfsr_state = 32'h50a2;
    tests_run = 0;
    tests_failed = 0;
    reset_dut();

    start_test();
    run_instr(16'h0000, 3'b000);
    finish_test("reset and fetch");

    start_test();
    for (int i = op_ld_a; i <= op_jmp; i++) begin
      draw_bits(3, flags);
      run_instr(16'(i), flags[2:0]);
    end
    finish_test("transfers");

    // Each jump sees its own flag clear, then set, with the other flags opposite
    start_test();
    for (int f = 0; f < 2; f++) begin
      run_instr(op_jiz, (f == 1) ? 3'b100 : 3'b011);
      run_instr(op_jic, (f == 1) ? 3'b010 : 3'b101);
      run_instr(op_jio, (f == 1) ? 3'b001 : 3'b110);
    end
    finish_test("conditional jumps");

    start_test();
    for (int i = op_addi; i <= op_chk; i++) begin
      draw_bits(3, flags);
      run_instr(16'(i), flags[2:0]);
    end
    finish_test("alu");

    start_test();
    for (int n = 0; n < n_random; n++) begin
      do begin
        draw_bits(16, op);
      end while (!is_unknown(op));
      draw_bits(3, flags);
      run_instr(op, flags[2:0]);
    end
    finish_test("nop");

    start_test();
    @(posedge clk);
    instruction <= op_halt;
    repeat (halt_cycles) @(posedge clk);
    reset_dut();
    repeat (2) @(negedge clk);
    finish_test("halt");

    $display("tests %0d, ok %0d, failed %0d, assertion failures %0d", tests_run,
             tests_run - tests_failed, tests_failed, i_instruction_decoder.u_chk.fail_count);
    if (tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+hw
hw/ucode_pkg.sv
hw/ucode_if.sv
hw/transfer_decoder.sv
hw/alu_op_decoder.sv
hw/microcode_sequencer.sv
hw/instruction_decoder.sv
tb/tb_clk_gen.sv
tb/instruction_decoder_chk.sv
tb/instruction_decoder_tb.sv
